//--- src/audio_defines.svh
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

////////////////////
// APB register map
////////////////////

// Byte addresses of the four registers
`define ADDR_CTRL 8'h00
`define ADDR_LDIV 8'h04
`define ADDR_RDIV 8'h08
`define ADDR_VOL  8'h0C

////////////////////
// I2S clocking
////////////////////

// Free-running divider, one frame per wrap
`define DIV_WIDTH 9
`define SLOT_BITS 16

`endif

//--- src/audio_pkg.sv
package audio_pkg;

    // Signed two's-complement PCM sample
    typedef logic signed [15:0] sample_t;

    // Tone half-period in frames
    typedef logic [15:0] divisor_t;

    // Square-wave amplitude magnitude
    typedef logic [14:0] volume_t;

    // APB byte address
    typedef logic [7:0] apb_addr_t;

    // Phase of one tone channel
    typedef enum logic [1:0] {
        tone_idle = 2'd0,
        tone_high = 2'd1,
        tone_low  = 2'd2
    } tone_state_t;

endpackage

//--- src/audio_regs.sv
`include "audio_defines.svh"

module audio_regs (
    input  logic                fcrystal,
    input  logic                rst_n,
    input  audio_pkg::apb_addr_t paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                enable,
    output audio_pkg::divisor_t left_div,
    output audio_pkg::divisor_t right_div,
    output audio_pkg::volume_t  volume
);

    logic        setup_phase;
    logic        access_phase;
    logic        addr_hit;
    logic [31:0] rd_mux;

    assign setup_phase  = psel && !penable;
    assign access_phase = psel && penable;

    // Every access completes in one cycle
    assign pready = 1'b1;

    ////////////////////
    // Address decode
    ////////////////////

    always_comb begin
        addr_hit = 1'b1;
        rd_mux   = 32'd0;
        case (paddr)
            `ADDR_CTRL: rd_mux = {31'd0, enable};
            `ADDR_LDIV: rd_mux = {16'd0, left_div};
            `ADDR_RDIV: rd_mux = {16'd0, right_div};
            `ADDR_VOL:  rd_mux = {17'd0, volume};
            default:    addr_hit = 1'b0;
        endcase
    end

    // Response captured in setup, presented during the access cycle
    always_ff @(posedge fcrystal or negedge rst_n) begin
        if (!rst_n) begin
            prdata  <= 32'd0;
            pslverr <= 1'b0;
        end else if (setup_phase) begin
            prdata  <= pwrite ? 32'd0 : rd_mux;
            pslverr <= !addr_hit;
        end else begin
            prdata  <= 32'd0;
            pslverr <= 1'b0;
        end
    end

    ////////////////////
    // Register writes
    ////////////////////

    always_ff @(posedge fcrystal or negedge rst_n) begin
        if (!rst_n) begin
            enable    <= 1'b0;
            left_div  <= '0;
            right_div <= '0;
            volume    <= '0;
        end else if (access_phase && pwrite) begin
            case (paddr)
                `ADDR_CTRL: enable <= pwdata[0];
                `ADDR_LDIV: left_div <= pwdata[15:0];
                `ADDR_RDIV: right_div <= pwdata[15:0];
                `ADDR_VOL:  volume <= pwdata[14:0];
                default: ;
            endcase
        end
    end

    // Error response only ever seen by the master in its access cycle
    a_pslverr_in_access: assert property (
        @(posedge fcrystal) disable iff (!rst_n)
        pslverr |-> (psel && penable)
    ) else $error("pslverr raised outside an APB access cycle");

endmodule

//--- src/tone_gen.sv
module tone_gen (
    input  logic                fcrystal,
    input  logic                rst_n,
    input  logic                frame_start,
    input  logic                enable,
    input  audio_pkg::divisor_t left_div,
    input  audio_pkg::divisor_t right_div,
    input  audio_pkg::volume_t  volume,
    output audio_pkg::sample_t  audio_left,
    output audio_pkg::sample_t  audio_right
);

    audio_pkg::divisor_t ch_div    [2];
    audio_pkg::sample_t  ch_sample [2];
    audio_pkg::sample_t  pos_level;
    audio_pkg::sample_t  neg_level;

    assign ch_div[0] = left_div;
    assign ch_div[1] = right_div;

    // Both square-wave levels, shared by the channels
    assign pos_level = audio_pkg::sample_t'({1'b0, volume});
    assign neg_level = -pos_level;

    for (genvar ch = 0; ch < 2; ch++) begin : g_chan
        audio_pkg::tone_state_t state_q;
        audio_pkg::divisor_t    count_q;
        audio_pkg::sample_t     sample_q;
        logic                   run;
        logic [15:0]            magnitude;

        assign run = enable && (ch_div[ch] != '0);

        // Advances once per frame, count_q holds frames spent in the phase
        always_ff @(posedge fcrystal or negedge rst_n) begin
            if (!rst_n) begin
                state_q  <= audio_pkg::tone_idle;
                count_q  <= '0;
                sample_q <= '0;
            end else if (frame_start) begin
                if (!run) begin
                    state_q  <= audio_pkg::tone_idle;
                    count_q  <= '0;
                    sample_q <= '0;
                end else begin
                    case (state_q)
                        audio_pkg::tone_high: begin
                            if (count_q >= ch_div[ch]) begin
                                state_q  <= audio_pkg::tone_low;
                                count_q  <= 16'd1;
                                sample_q <= neg_level;
                            end else begin
                                count_q  <= count_q + 16'd1;
                                sample_q <= pos_level;
                            end
                        end
                        audio_pkg::tone_low: begin
                            if (count_q >= ch_div[ch]) begin
                                state_q  <= audio_pkg::tone_high;
                                count_q  <= 16'd1;
                                sample_q <= pos_level;
                            end else begin
                                count_q  <= count_q + 16'd1;
                                sample_q <= neg_level;
                            end
                        end
                        default: begin
                            // Leaving idle always starts with the high half
                            state_q  <= audio_pkg::tone_high;
                            count_q  <= 16'd1;
                            sample_q <= pos_level;
                        end
                    endcase
                end
            end
        end

        assign ch_sample[ch] = sample_q;
        assign magnitude     = sample_q[15] ? 16'(-sample_q) : 16'(sample_q);

        a_within_volume: assert property (
            @(posedge fcrystal) disable iff (!rst_n)
            $past(frame_start) |-> (magnitude <= {1'b0, $past(volume)})
        ) else $error("tone sample exceeds the programmed volume");
    end

    assign audio_left  = ch_sample[0];
    assign audio_right = ch_sample[1];

endmodule

//--- src/speaker_control.sv
`include "audio_defines.svh"

module speaker_control (
    input  logic               fcrystal,
    input  logic               rst_n,
    input  audio_pkg::sample_t audio_left,
    input  audio_pkg::sample_t audio_right,
    output logic               audio_mclk,
    output logic               audio_lrck,
    output logic               audio_sck,
    output logic               audio_din,
    output logic               frame_start
);

    localparam int SLOT_W = $clog2(`SLOT_BITS);

    logic [`DIV_WIDTH-1:0] div_q;
    logic [SLOT_W:0]       bit_q;
    logic [SLOT_W:0]       bit_next;
    logic [SLOT_W-1:0]     bit_idx;
    logic                  sck_fall;
    logic                  sel_right;
    logic                  din_next;
    audio_pkg::sample_t    left_q;
    audio_pkg::sample_t    right_q;

    ////////////////////
    // Clock divider
    ////////////////////

    always_ff @(posedge fcrystal or negedge rst_n) begin
        if (!rst_n) begin
            div_q       <= '0;
            frame_start <= 1'b0;
        end else begin
            div_q       <= div_q + `DIV_WIDTH'(1);
            // High in the cycle where the divider sits at zero
            frame_start <= &div_q;
        end
    end

    assign audio_mclk = div_q[1];
    assign audio_sck  = div_q[3];
    assign audio_lrck = div_q[`DIV_WIDTH-1];

    // SCK drops on the next edge
    assign sck_fall = &div_q[3:0];

    ////////////////////
    // I2S serializer
    ////////////////////

    assign bit_next = bit_q + (SLOT_W + 1)'(1);

    // Positions 1 to 15 give bits 15 down to 1, position 0 gives bit 0
    assign bit_idx = -bit_next[SLOT_W-1:0];

    // First bit of a slot still belongs to the other channel's word
    assign sel_right = bit_next[SLOT_W] ^ (bit_next[SLOT_W-1:0] == '0);
    assign din_next  = sel_right ? right_q[bit_idx] : left_q[bit_idx];

    always_ff @(posedge fcrystal or negedge rst_n) begin
        if (!rst_n) begin
            bit_q     <= '0;
            audio_din <= 1'b0;
        end else if (sck_fall) begin
            bit_q     <= bit_next;
            audio_din <= din_next;
        end
    end

    // Sample latch, one frame behind the tone generator
    always_ff @(posedge fcrystal or negedge rst_n) begin
        if (!rst_n) begin
            left_q  <= '0;
            right_q <= '0;
        end else if (frame_start) begin
            left_q  <= audio_left;
            right_q <= audio_right;
        end
    end

    a_lrck_sck_low: assert property (
        @(posedge fcrystal) disable iff (!rst_n)
        $changed(audio_lrck) |-> !audio_sck
    ) else $error("LRCK toggled while SCK was high");

endmodule

//--- src/audio_top.sv
module audio_top (
    input  logic                 fcrystal,
    input  logic                 rst_n,
    input  audio_pkg::apb_addr_t paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic                 audio_mclk,
    output logic                 audio_lrck,
    output logic                 audio_sck,
    output logic                 audio_din
);

    logic                enable;
    audio_pkg::divisor_t left_div;
    audio_pkg::divisor_t right_div;
    audio_pkg::volume_t  volume;
    audio_pkg::sample_t  audio_left;
    audio_pkg::sample_t  audio_right;
    logic                frame_start;

    // CPU-side register file
    audio_regs i_audio_regs (
        .fcrystal  (fcrystal),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .enable    (enable),
        .left_div  (left_div),
        .right_div (right_div),
        .volume    (volume)
    );

    // Samples advance on the frame strobe from the speaker side
    tone_gen i_tone_gen (
        .fcrystal    (fcrystal),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .enable      (enable),
        .left_div    (left_div),
        .right_div   (right_div),
        .volume      (volume),
        .audio_left  (audio_left),
        .audio_right (audio_right)
    );

    speaker_control i_speaker_control (
        .fcrystal    (fcrystal),
        .rst_n       (rst_n),
        .audio_left  (audio_left),
        .audio_right (audio_right),
        .audio_mclk  (audio_mclk),
        .audio_lrck  (audio_lrck),
        .audio_sck   (audio_sck),
        .audio_din   (audio_din),
        .frame_start (frame_start)
    );

endmodule

//--- sim/i2s_monitor.sv
module i2s_monitor (
    input  logic               fcrystal,
    input  logic               rst_n,
    input  logic               mclk,
    input  logic               sck,
    input  logic               lrck,
    input  logic               din,
    output logic signed [15:0] left_word,
    output logic signed [15:0] right_word,
    output int                 left_count,
    output int                 right_count,
    output int                 errors
);

    timeunit 1ns;
    timeprecision 1ps;

    logic        mclk_q;
    logic        sck_q;
    logic        lrck_q;
    logic        lrck_seen;
    int          mclk_len;
    int          sck_len;
    int          lrck_len;
    logic [15:0] shift_q;
    logic        slot_lrck;
    int          slot_cycles;
    int          clk_errors;
    int          slot_errors;

    // Period errors and slot errors come from different clocks
    assign errors = clk_errors + slot_errors;

    ////////////////////
    // Clock periods
    ////////////////////

    // Each length counts fcrystal cycles since the last rising edge
    always @(posedge fcrystal or negedge rst_n) begin
        if (!rst_n) begin
            mclk_q    <= 1'b0;
            sck_q     <= 1'b0;
            lrck_q    <= 1'b0;
            lrck_seen <= 1'b0;
            mclk_len  <= 0;
            sck_len   <= 0;
            lrck_len  <= 0;
        end else begin
            mclk_q   <= mclk;
            sck_q    <= sck;
            lrck_q   <= lrck;
            mclk_len <= (mclk && !mclk_q) ? 1 : mclk_len + 1;
            sck_len  <= (sck && !sck_q) ? 1 : sck_len + 1;
            lrck_len <= (lrck && !lrck_q) ? 1 : lrck_len + 1;
            if (lrck && !lrck_q) begin
                lrck_seen <= 1'b1;
            end
        end
    end

    a_mclk_period: assert property (
        @(posedge fcrystal) disable iff (!rst_n)
        (lrck_seen && mclk && !mclk_q) |-> (mclk_len == 4)
    ) else begin
        clk_errors++;
        $display("MCLK period at %0t ns is not 4 fcrystal cycles", $time);
    end

    a_sck_period: assert property (
        @(posedge fcrystal) disable iff (!rst_n)
        (lrck_seen && sck && !sck_q) |-> (sck_len == 16)
    ) else begin
        clk_errors++;
        $display("SCK period at %0t ns is not 16 fcrystal cycles", $time);
    end

    a_lrck_period: assert property (
        @(posedge fcrystal) disable iff (!rst_n)
        (lrck_seen && lrck && !lrck_q) |-> (lrck_len == 512)
    ) else begin
        clk_errors++;
        $display("LRCK period at %0t ns is not 512 fcrystal cycles", $time);
    end

    ////////////////////
    // Word decode
    ////////////////////

    // First SCK of a slot carries the LSB of the word from the slot before
    always @(posedge sck or negedge rst_n) begin
        if (!rst_n) begin
            shift_q     <= '0;
            slot_lrck   <= 1'b0;
            slot_cycles <= 0;
            left_word   <= '0;
            right_word  <= '0;
            left_count  <= 0;
            right_count <= 0;
        end else if (lrck != slot_lrck) begin
            if (slot_lrck) begin
                right_word  <= {shift_q[14:0], din};
                right_count <= right_count + 1;
            end else begin
                left_word  <= {shift_q[14:0], din};
                left_count <= left_count + 1;
            end
            if (slot_cycles != 16) begin
                slot_errors++;
                $display("LRCK half at %0t ns held %0d SCK cycles instead of 16",
                         $time, slot_cycles);
            end
            slot_cycles <= 1;
            slot_lrck   <= lrck;
            shift_q     <= '0;
        end else begin
            shift_q     <= {shift_q[14:0], din};
            slot_cycles <= slot_cycles + 1;
        end
    end

    initial begin
        clk_errors  = 0;
        slot_errors = 0;
    end

endmodule

//--- sim/tb_audio_top.sv
`include "audio_defines.svh"

module tb_audio_top;

    timeunit 1ns;
    timeprecision 1ps;

    // Frames of all tests together, with some spare
    localparam int  TEST_FRAMES = 90;
    localparam int  SPARE_FRAMES = 20;
    localparam real TIMEOUT_NS = (TEST_FRAMES + SPARE_FRAMES) * 512 * 40.0;

    logic                 fcrystal;
    logic                 rst_n;
    audio_pkg::apb_addr_t paddr;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [31:0]          pwdata;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 mclk;
    logic                 lrck;
    logic                 sck;
    logic                 din;
    logic signed [15:0]   left_word;
    logic signed [15:0]   right_word;
    int                   left_count;
    int                   right_count;
    int                   mon_errors;
    int                   errors;
    logic [31:0]          seed;
    logic                 capture;
    logic signed [15:0]   lq [$];
    logic signed [15:0]   rq [$];

    audio_top i_audio_top (
        .fcrystal   (fcrystal),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .audio_mclk (mclk),
        .audio_lrck (lrck),
        .audio_sck  (sck),
        .audio_din  (din)
    );

    i2s_monitor i_mon (
        .fcrystal    (fcrystal),
        .rst_n       (rst_n),
        .mclk        (mclk),
        .sck         (sck),
        .lrck        (lrck),
        .din         (din),
        .left_word   (left_word),
        .right_word  (right_word),
        .left_count  (left_count),
        .right_count (right_count),
        .errors      (mon_errors)
    );

    always #20 fcrystal = ~fcrystal;

    always @(left_count) if (capture) lq.push_back(left_word);
    always @(right_count) if (capture) rq.push_back(right_word);

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Mismatch at %0t ns: %s", $time, msg);
    endtask

    a_reset_quiet: assert property (
        @(posedge fcrystal) !rst_n |-> !(mclk || sck || lrck || din)
    ) else report_mismatch("audio clocks or DIN not low during reset");

    // No wait states on this slave
    a_pready_in_access: assert property (
        @(posedge fcrystal) disable iff (!rst_n)
        (psel && penable) |-> pready
    ) else report_mismatch("pready low in an APB access cycle");

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    ////////////////////
    // APB master
    ////////////////////

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        @(negedge fcrystal);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge fcrystal);
        penable = 1'b1;
        while (!pready) @(negedge fcrystal);
        err = pslverr;
        @(negedge fcrystal);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        @(negedge fcrystal);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge fcrystal);
        penable = 1'b1;
        while (!pready) @(negedge fcrystal);
        data = prdata;
        err  = pslverr;
        @(negedge fcrystal);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        assert (data == exp && !err)
        else report_mismatch($sformatf("reg 0x%02h read 0x%08h err %0b, expected 0x%08h",
                                       addr, data, err, exp));
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        assert (!err) else report_mismatch($sformatf("write to 0x%02h got pslverr", addr));
    endtask

    ////////////////////
    // Word capture and rules
    ////////////////////

    task automatic skip_frames(input int n);
        repeat (n) @(right_count);
    endtask

    task automatic collect_words(input int n);
        lq.delete();
        rq.delete();
        capture = 1'b1;
        while (lq.size() < n || rq.size() < n) @(posedge fcrystal);
        capture = 1'b0;
    endtask

    task automatic check_silent(input logic signed [15:0] words [$], input string name);
        foreach (words[i]) begin
            assert (words[i] == 0)
            else report_mismatch($sformatf("%s word %0d is %0d, expected 0", name, i, words[i]));
        end
    endtask

    // Square wave of +v/-v runs, each run d frames long
    task automatic check_tone(input logic signed [15:0] words [$], input int d, input int v,
                              input bit from_idle, input string name);
        int first;
        int cur;
        int run;
        int val;
        bit known;
        first = -1;
        foreach (words[i]) begin
            val = words[i];
            if (first < 0 && val != 0) first = i;
        end
        assert (first >= 0) else report_mismatch($sformatf("%s tone never started", name));
        if (first < 0) return;
        cur = words[first];
        assert (from_idle ? cur == v : (cur == v || cur == -v))
        else report_mismatch($sformatf("%s tone starts at %0d, expected %0d", name, cur, v));
        // A run cut by the start of the capture is only bounded by d
        run   = 1;
        known = from_idle;
        for (int i = first + 1; i < words.size(); i++) begin
            val = words[i];
            if (val == cur) begin
                run++;
            end else begin
                assert (val == -cur && (cur == v || cur == -v))
                else report_mismatch($sformatf("%s word %0d is %0d after %0d", name, i, val, cur));
                assert (known ? run == d : run <= d)
                else report_mismatch($sformatf("%s run of %0d frames, expected %0d",
                                               name, run, d));
                cur   = val;
                run   = 1;
                known = 1'b1;
            end
        end
        assert (run <= d) else report_mismatch($sformatf("%s run longer than %0d", name, d));
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        logic [7:0]  addrs [4];
        logic [31:0] masks [4];
        logic [31:0] kept [4];
        logic [31:0] data;
        logic        err;
        int          ld;
        int          rd;
        int          vol;

        addrs   = '{`ADDR_CTRL, `ADDR_LDIV, `ADDR_RDIV, `ADDR_VOL};
        masks   = '{32'h1, 32'hFFFF, 32'hFFFF, 32'h7FFF};
        errors  = 0;
        seed    = 32'h5bce;
        capture = 1'b0;
        fcrystal = 1'b0;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;

        repeat (4) @(negedge fcrystal);
        rst_n = 1'b1;
        assert (!(mclk || sck || lrck || din))
        else report_mismatch("audio clocks or DIN not low after reset");
        foreach (addrs[i]) check_reg(addrs[i], 32'd0);

        // Register readback, masked to width
        foreach (addrs[i]) begin
            data = next_rand();
            write_reg(addrs[i], data);
            kept[i] = data & masks[i];
            check_reg(addrs[i], kept[i]);
        end

        // Unmapped address
        apb_write(8'h10, next_rand(), err);
        assert (err) else report_mismatch("write to 0x10 gave no pslverr");
        apb_read(8'h10, data, err);
        assert (err && data == 0)
        else report_mismatch($sformatf("read of 0x10 gave 0x%08h err %0b", data, err));
        foreach (addrs[i]) check_reg(addrs[i], kept[i]);

        // Disabled output
        write_reg(`ADDR_CTRL, 32'd0);
        write_reg(`ADDR_LDIV, 32'd3);
        write_reg(`ADDR_RDIV, 32'd2);
        write_reg(`ADDR_VOL, 32'd1000);
        skip_frames(3);
        collect_words(8);
        check_silent(lq, "left");
        check_silent(rq, "right");

        // Left tone
        ld  = (next_rand() >> 16) % 4 + 1;
        vol = ((next_rand() >> 8) & 32'h3FFF) + 1;
        write_reg(`ADDR_LDIV, ld);
        write_reg(`ADDR_RDIV, 32'd0);
        write_reg(`ADDR_VOL, vol);
        write_reg(`ADDR_CTRL, 32'd1);
        collect_words(24);
        check_tone(lq, ld, vol, 1'b1, "left");
        check_silent(rq, "right");

        // Both channels, then right muted
        write_reg(`ADDR_CTRL, 32'd0);
        skip_frames(3);
        ld  = (next_rand() >> 16) % 4 + 1;
        rd  = ld % 4 + 1;
        vol = ((next_rand() >> 8) & 32'h3FFF) + 1;
        write_reg(`ADDR_LDIV, ld);
        write_reg(`ADDR_RDIV, rd);
        write_reg(`ADDR_VOL, vol);
        write_reg(`ADDR_CTRL, 32'd1);
        collect_words(24);
        check_tone(lq, ld, vol, 1'b1, "left");
        check_tone(rq, rd, vol, 1'b1, "right");
        write_reg(`ADDR_RDIV, 32'd0);
        skip_frames(3);
        collect_words(12);
        check_tone(lq, ld, vol, 1'b0, "left");
        check_silent(rq, "right");

        $display("Closing count: %0d check errors, %0d monitor errors", errors, mon_errors);
        if (errors == 0 && mon_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the tests finished");
        $display("Errors found");
        $finish;
    end

endmodule

//--- files.f
+incdir+src
src/audio_pkg.sv
src/audio_regs.sv
src/tone_gen.sv
src/speaker_control.sv
src/audio_top.sv
sim/i2s_monitor.sv
sim/tb_audio_top.sv

//--- Makefile
TOP = tb_audio_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
